// ==== source/spuMixPkg.sv ====
package spuMixPkg;

	// --------------------
	// Widths and limits
	// --------------------
	localparam int SAMPLE_W   = 16;
	// Room for 32 full scale voices
	localparam int SUM_W      = 21;
	localparam int MAX_VOICES = 32;

	// Audio sample and voice sum
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SUM_W-1:0]    sum_t;

	// Stereo pair for CD input, stored CD sample and DAC output
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// One voice contribution for the current frame
	typedef struct packed {
		sample_t left;
		sample_t right;
		logic    reverbSend;
	} voice_t;

	// Reverb side alternates every frame
	typedef enum logic {
		SIDE_LEFT  = 1'b0,
		SIDE_RIGHT = 1'b1
	} side_e;

	// Sums of one closed frame
	typedef struct packed {
		sum_t  left;
		sum_t  right;
		sum_t  reverb;
		side_e side;
	} frameSums_t;

	// Mixer control registers
	typedef struct packed {
		logic    spuNotMuted;
		logic    cdEnable;
		logic    cdToReverb;
		logic    reverbEnable;
		sample_t cdVolLeft;
		sample_t cdVolRight;
		sample_t mainVolLeft;
		sample_t mainVolRight;
		sample_t reverbVolLeft;
		sample_t reverbVolRight;
	} mixRegs_t;

	// Saturate a wide sum to the 16-bit sample range
	function automatic sample_t clampToSample(input sum_t value);
		sample_t result;
		if (value > sum_t'(32767)) begin
			result = 16'sh7FFF;
		end else if (value < -sum_t'(32768)) begin
			result = 16'sh8000;
		end else begin
			result = value[SAMPLE_W-1:0];
		end
		return result;
	endfunction

endpackage

// ==== source/voiceSummer.sv ====
`timescale 1ns/100ps

module voiceSummer (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_voiceValid,
	input  spuMixPkg::voice_t     i_voice,
	input  logic                  i_frameEnd,
	output spuMixPkg::frameSums_t o_frame,
	output logic                  o_frameValid
);
	import spuMixPkg::*;

	// Counter must reach MAX_VOICES itself
	localparam int CNT_W = $clog2(MAX_VOICES + 1);

	// Running sums of the open frame
	sum_t accLeft;
	sum_t accRight;
	sum_t accReverb;
	logic [CNT_W-1:0] voiceCount;
	side_e side;

	// Contribution of the voice in this cycle
	sum_t addLeft;
	sum_t addRight;
	sum_t addReverb;
	sum_t nextLeft;
	sum_t nextRight;
	sum_t nextReverb;
	sample_t sendSample;

	// --------------------
	// Next sums
	// --------------------
	always_comb begin
		// Reverb send takes the channel of the current side
		if (side == SIDE_LEFT) begin
			sendSample = i_voice.left;
		end else begin
			sendSample = i_voice.right;
		end

		addLeft   = '0;
		addRight  = '0;
		addReverb = '0;
		if (i_voiceValid) begin
			// Sign extension to sum width
			addLeft  = i_voice.left;
			addRight = i_voice.right;
			if (i_voice.reverbSend) begin
				addReverb = sendSample;
			end
		end

		// A voice in the frame end cycle still belongs to this frame
		nextLeft   = accLeft + addLeft;
		nextRight  = accRight + addRight;
		nextReverb = accReverb + addReverb;
	end

	// --------------------
	// Accumulators and side
	// --------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			accLeft      <= '0;
			accRight     <= '0;
			accReverb    <= '0;
			voiceCount   <= '0;
			side         <= SIDE_LEFT;
			o_frameValid <= 1'b0;
		end else begin
			o_frameValid <= i_frameEnd;
			if (i_frameEnd) begin
				// Clear for the next frame and flip the reverb side
				accLeft    <= '0;
				accRight   <= '0;
				accReverb  <= '0;
				voiceCount <= '0;
				side       <= (side == SIDE_LEFT) ? SIDE_RIGHT : SIDE_LEFT;
			end else if (i_voiceValid) begin
				accLeft    <= nextLeft;
				accRight   <= nextRight;
				accReverb  <= nextReverb;
				voiceCount <= voiceCount + 1'b1;
			end
		end
	end

	// Closed frame sums, tagged with the side they were built for
	always_ff @(posedge i_clk) begin
		if (i_frameEnd) begin
			o_frame.left   <= nextLeft;
			o_frame.right  <= nextRight;
			o_frame.reverb <= nextReverb;
			o_frame.side   <= side;
		end
	end

	// Sum width only covers MAX_VOICES full scale voices
	voiceLimit: assert property (@(posedge i_clk) disable iff (i_rst)
		voiceCount <= CNT_W'(MAX_VOICES));

	// Mixer expects isolated frame strobes
	frameStrobe: assert property (@(posedge i_clk) disable iff (i_rst)
		o_frameValid |=> !o_frameValid);

endmodule

// ==== source/cdAudioFifo.sv ====
`timescale 1ns/100ps

module cdAudioFifo #(
	parameter int DEPTH = 8
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_cdValid,
	input  spuMixPkg::stereo_t i_cdSample,
	input  logic               i_pop,
	output spuMixPkg::stereo_t o_head,
	output logic               o_avail,
	output logic               o_cdDropped
);
	import spuMixPkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Sample storage
	stereo_t mem [DEPTH];

	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] count;
	logic full;
	logic doPush;

	// Wrap at DEPTH so any depth works
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] result;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	assign full   = (count == CNT_W'(DEPTH));
	// Writes while full are lost
	assign doPush = i_cdValid && !full;

	// --------------------
	// Pointers and fill
	// --------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			rdPtr       <= '0;
			wrPtr       <= '0;
			count       <= '0;
			o_cdDropped <= 1'b0;
		end else begin
			o_cdDropped <= i_cdValid && full;
			if (doPush) begin
				wrPtr <= nextPtr(wrPtr);
			end
			// Consumer only pops when data is there
			if (i_pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({doPush, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage write
	always_ff @(posedge i_clk) begin
		if (doPush) begin
			mem[wrPtr] <= i_cdSample;
		end
	end

	// Oldest sample shows at the head
	assign o_head  = mem[rdPtr];
	assign o_avail = (count != '0);

	// Pop on empty would hand the mixer a stale slot
	noEmptyPop: assert property (@(posedge i_clk) disable iff (i_rst)
		i_pop |-> o_avail);

	fillBound: assert property (@(posedge i_clk) disable iff (i_rst)
		count <= CNT_W'(DEPTH));

endmodule

// ==== source/audioMixer.sv ====
`timescale 1ns/100ps

module audioMixer (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  spuMixPkg::frameSums_t i_frame,
	input  logic                  i_frameValid,
	input  spuMixPkg::stereo_t    i_head,
	input  logic                  i_avail,
	input  spuMixPkg::mixRegs_t   i_regs,
	input  spuMixPkg::sample_t    i_reverbReturn,
	output logic                  o_pop,
	output spuMixPkg::stereo_t    o_dac,
	output logic                  o_dacValid,
	output spuMixPkg::sample_t    o_lineIn,
	output spuMixPkg::stereo_t    o_storedCd
);
	import spuMixPkg::*;

	// Held CD sample and reverb returns per side
	stereo_t storedCd;
	sample_t revLeft;
	sample_t revRight;

	// --------------------
	// CD volume
	// --------------------
	logic signed [31:0] cdProdLeft;
	logic signed [31:0] cdProdRight;
	sample_t cdSideLeft;
	sample_t cdSideRight;

	// Q15 scaling, floor by arithmetic shift
	assign cdProdLeft  = storedCd.left * i_regs.cdVolLeft;
	assign cdProdRight = storedCd.right * i_regs.cdVolRight;
	assign cdSideLeft  = i_regs.cdEnable ? cdProdLeft[30:15] : '0;
	assign cdSideRight = i_regs.cdEnable ? cdProdRight[30:15] : '0;

	// --------------------
	// Main volume
	// --------------------
	logic signed [14:0] volLeft;
	logic signed [14:0] volRight;
	logic signed [35:0] mainProdLeft;
	logic signed [35:0] mainProdRight;
	sum_t mainLeft;
	sum_t mainRight;

	// Only 15 bits of main volume are used
	// Mute forces zero on the voices and leaves CD alone
	assign volLeft       = i_regs.spuNotMuted ? i_regs.mainVolLeft[14:0] : '0;
	assign volRight      = i_regs.spuNotMuted ? i_regs.mainVolRight[14:0] : '0;
	assign mainProdLeft  = i_frame.left * volLeft;
	assign mainProdRight = i_frame.right * volRight;
	assign mainLeft      = mainProdLeft[34:14];
	assign mainRight     = mainProdRight[34:14];

	// --------------------
	// Reverb return
	// --------------------
	sample_t revVol;
	logic signed [31:0] revProd;
	sample_t revNew;

	// Volume of the side this frame was built for
	assign revVol  = (i_frame.side == SIDE_RIGHT) ? i_regs.reverbVolRight : i_regs.reverbVolLeft;
	assign revProd = i_reverbReturn * revVol;
	assign revNew  = i_regs.reverbEnable ? revProd[30:15] : '0;

	// --------------------
	// Mix and line input
	// --------------------
	sum_t mixLeft;
	sum_t mixRight;
	sample_t cdRevTerm;
	sum_t lineSum;

	// Voices plus CD plus reverb return held from earlier frames
	assign mixLeft  = mainLeft + cdSideLeft + revLeft;
	assign mixRight = mainRight + cdSideRight + revRight;

	always_comb begin
		cdRevTerm = '0;
		// CD into reverb uses the channel of the frame side
		if (i_regs.cdToReverb) begin
			if (i_frame.side == SIDE_RIGHT) begin
				cdRevTerm = cdSideRight;
			end else begin
				cdRevTerm = cdSideLeft;
			end
		end
		lineSum = i_frame.reverb + cdRevTerm;
	end

	// One CD sample per frame when there is one
	assign o_pop = i_frameValid && i_avail;

	// --------------------
	// Stored values
	// --------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			storedCd <= '0;
			revLeft  <= '0;
			revRight <= '0;
		end else if (i_frameValid) begin
			// Empty FIFO keeps the previous sample
			if (i_avail) begin
				storedCd <= i_head;
			end
			if (i_frame.side == SIDE_RIGHT) begin
				revRight <= revNew;
			end else begin
				revLeft  <= revNew;
			end
		end
	end

	// Registered DAC sample and line input
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_dac      <= '0;
			o_lineIn   <= '0;
			o_dacValid <= 1'b0;
		end else begin
			o_dacValid <= i_frameValid;
			if (i_frameValid) begin
				o_dac.left  <= clampToSample(mixLeft);
				o_dac.right <= clampToSample(mixRight);
				o_lineIn    <= clampToSample(lineSum);
			end
		end
	end

	assign o_storedCd = storedCd;

	// Frame sums reach the DAC registers on the strobe
	frameKnown: assert property (@(posedge i_clk) disable iff (i_rst)
		i_frameValid |-> !$isunknown(i_frame));

endmodule

// ==== source/spuAudioOut.sv ====
`timescale 1ns/100ps

module spuAudioOut #(
	parameter int CD_DEPTH = 8
) (
	input  logic                i_clk,
	input  logic                i_rst,
	// Voice samples and frame close
	input  logic                i_voiceValid,
	input  spuMixPkg::voice_t   i_voice,
	input  logic                i_frameEnd,
	// CD drive samples
	input  logic                i_cdValid,
	input  spuMixPkg::stereo_t  i_cdSample,
	// Register levels and reverb engine return
	input  spuMixPkg::mixRegs_t i_regs,
	input  spuMixPkg::sample_t  i_reverbReturn,
	// DAC side
	output spuMixPkg::stereo_t  o_dac,
	output logic                o_dacValid,
	output spuMixPkg::sample_t  o_lineIn,
	output spuMixPkg::stereo_t  o_storedCd,
	output logic                o_cdDropped
);
	import spuMixPkg::*;

	// Summer to mixer
	frameSums_t frame;
	logic frameValid;
	// FIFO and mixer
	stereo_t head;
	logic avail;
	logic pop;

	// Frame sums
	voiceSummer u_voiceSummer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_voiceValid (i_voiceValid),
		.i_voice      (i_voice),
		.i_frameEnd   (i_frameEnd),
		.o_frame      (frame),
		.o_frameValid (frameValid)
	);

	// CD buffer
	cdAudioFifo #(
		.DEPTH (CD_DEPTH)
	) u_cdAudioFifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cdValid   (i_cdValid),
		.i_cdSample  (i_cdSample),
		.i_pop       (pop),
		.o_head      (head),
		.o_avail     (avail),
		.o_cdDropped (o_cdDropped)
	);

	// Volumes, mix and clamp
	audioMixer u_audioMixer (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_frame        (frame),
		.i_frameValid   (frameValid),
		.i_head         (head),
		.i_avail        (avail),
		.i_regs         (i_regs),
		.i_reverbReturn (i_reverbReturn),
		.o_pop          (pop),
		.o_dac          (o_dac),
		.o_dacValid     (o_dacValid),
		.o_lineIn       (o_lineIn),
		.o_storedCd     (o_storedCd)
	);

endmodule

// ==== bench/spuAudioOutTb.sv ====
`timescale 1ns/100ps

module spuAudioOutTb;
	import spuMixPkg::*;

	// Small FIFO so overflow is easy to reach
	localparam int CD_DEPTH = 4;
	localparam int TIMEOUT_CYCLES = 16;

	// Expected response of one frame
	typedef struct packed {
		stereo_t dac;
		sample_t lineIn;
		stereo_t storedCd;
	} expect_t;

	logic clk;
	logic rst;
	logic voiceValid;
	voice_t voice;
	logic frameEnd;
	logic cdValid;
	stereo_t cdSample;
	mixRegs_t regs;
	sample_t reverbReturn;
	stereo_t dac;
	logic dacValid;
	sample_t lineIn;
	stereo_t storedCd;
	logic cdDropped;

	// Model state mirrored from the mixing rules
	int unsigned lcgState = 32'd99472;
	expect_t expQ[$];
	stereo_t cdQ[$];
	side_e modelSide;
	stereo_t modelCd;
	sample_t modelRevLeft;
	sample_t modelRevRight;
	int frameCount;
	int checkedCount;
	int errorCount;
	int i;

	spuAudioOut #(.CD_DEPTH(CD_DEPTH)) u_spuAudioOut (
		.i_clk(clk), .i_rst(rst), .i_voiceValid(voiceValid), .i_voice(voice),
		.i_frameEnd(frameEnd), .i_cdValid(cdValid), .i_cdSample(cdSample),
		.i_regs(regs), .i_reverbReturn(reverbReturn), .o_dac(dac),
		.o_dacValid(dacValid), .o_lineIn(lineIn), .o_storedCd(storedCd),
		.o_cdDropped(cdDropped)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// --------------------
	// Stimulus helpers
	// --------------------
	// LCG, upper half of the state only
	function automatic int unsigned randBelow(input int unsigned n);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return (lcgState >> 16) % n;
	endfunction

	function automatic sample_t randSample();
		int unsigned r;
		r = randBelow(65536);
		return r[15:0];
	endfunction

	// Low 15 bits stay small so sums fit 21 bits, top bit is noise
	function automatic sample_t randMainVol();
		int v;
		sample_t r;
		v = int'(randBelow(24001)) - 12000;
		r = v[15:0];
		r[15] = (randBelow(2) == 1);
		return r;
	endfunction

	// Signed product, floor shift by 15, low 16 bits kept
	function automatic int scaleQ15(input sample_t a, input sample_t b);
		int shifted;
		sample_t low;
		shifted = (int'(a) * int'(b)) >>> 15;
		low = shifted[15:0];
		return int'(low);
	endfunction

	function automatic sample_t clampRef(input longint v);
		if (v > 32767) return 16'sh7FFF;
		if (v < -32768) return 16'sh8000;
		return v[15:0];
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic expect_t mixRef(input int sumLeft, input int sumRight, input int sumRev,
		input side_e side, input mixRegs_t r, input stereo_t cd, input sample_t revL,
		input sample_t revR);
		expect_t e;
		int cdLeft;
		int cdRight;
		logic signed [14:0] vol15;
		longint volLeft;
		longint volRight;
		cdLeft = r.cdEnable ? scaleQ15(cd.left, r.cdVolLeft) : 0;
		cdRight = r.cdEnable ? scaleQ15(cd.right, r.cdVolRight) : 0;
		// Mute zeroes main volume only
		vol15 = r.mainVolLeft[14:0];
		volLeft = r.spuNotMuted ? vol15 : 0;
		vol15 = r.mainVolRight[14:0];
		volRight = r.spuNotMuted ? vol15 : 0;
		e.dac.left = clampRef(((sumLeft * volLeft) >>> 14) + cdLeft + revL);
		e.dac.right = clampRef(((sumRight * volRight) >>> 14) + cdRight + revR);
		// CD into reverb follows the frame side
		e.lineIn = clampRef(sumRev + (!r.cdToReverb ? 0 : (side == SIDE_RIGHT) ? cdRight : cdLeft));
		e.storedCd = '0;
		return e;
	endfunction

	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkEqual(input int actual, input int expected, input string what);
		if (actual !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
			abortRun();
		end
	endtask

	task automatic randomRegs();
		regs.spuNotMuted = (randBelow(4) != 0);
		regs.cdEnable = (randBelow(4) != 0);
		regs.cdToReverb = (randBelow(2) == 0);
		regs.reverbEnable = (randBelow(3) != 0);
		regs.cdVolLeft = randSample();
		regs.cdVolRight = randSample();
		regs.mainVolLeft = randMainVol();
		regs.mainVolRight = randMainVol();
		regs.reverbVolLeft = randSample();
		regs.reverbVolRight = randSample();
		reverbReturn = randSample();
	endtask

	// One push, dropped when the mirrored queue is full
	task automatic pushCd(input stereo_t s);
		logic expDrop;
		expDrop = (cdQ.size() == CD_DEPTH);
		if (!expDrop) cdQ.push_back(s);
		cdValid = 1'b1;
		cdSample = s;
		@(posedge clk);
		#2;
		cdValid = 1'b0;
		checkEqual(cdDropped, expDrop, "o_cdDropped");
	endtask

	// Pushes, then voices, then frame end, then wait for the DAC sample
	task automatic runFrame(input int nVoices, input int nPushes);
		int sumLeft;
		int sumRight;
		int sumRev;
		int n;
		int waited;
		bit joinEnd;
		voice_t v;
		expect_t e;
		sample_t revNew;
		sumLeft = 0;
		sumRight = 0;
		sumRev = 0;
		for (n = 0; n < nPushes; n++) begin
			pushCd({randSample(), randSample()});
			if (randBelow(3) == 0) begin
				@(posedge clk);
				#2;
			end
		end
		// Last voice may share the frame end cycle
		joinEnd = (nVoices > 0) && (randBelow(2) == 0);
		for (n = 0; n < nVoices; n++) begin
			v = {randSample(), randSample(), randBelow(2) == 1};
			sumLeft += v.left;
			sumRight += v.right;
			if (v.reverbSend) sumRev += (modelSide == SIDE_RIGHT) ? v.right : v.left;
			voiceValid = 1'b1;
			voice = v;
			frameEnd = joinEnd && (n == nVoices - 1);
			@(posedge clk);
			#2;
		end
		voiceValid = 1'b0;
		if (!joinEnd) begin
			frameEnd = 1'b1;
			@(posedge clk);
			#2;
		end
		frameEnd = 1'b0;
		// Mix uses state from before the pop and the reverb update
		e = mixRef(sumLeft, sumRight, sumRev, modelSide, regs, modelCd, modelRevLeft,
			modelRevRight);
		if (cdQ.size() > 0) modelCd = cdQ.pop_front();
		revNew = regs.reverbEnable ? scaleQ15(reverbReturn, (modelSide == SIDE_RIGHT) ?
			regs.reverbVolRight : regs.reverbVolLeft) : '0;
		if (modelSide == SIDE_RIGHT) modelRevRight = revNew;
		else modelRevLeft = revNew;
		modelSide = (modelSide == SIDE_RIGHT) ? SIDE_LEFT : SIDE_RIGHT;
		e.storedCd = modelCd;
		expQ.push_back(e);
		frameCount++;
		waited = 0;
		while (checkedCount < frameCount) begin
			@(posedge clk);
			#2;
			waited++;
			// Drop flag only pulses in the cycle after a push
			checkEqual(cdDropped, 0, "o_cdDropped without a push");
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timeout: no DAC output for frame %0d", frameCount);
				abortRun();
			end
		end
		// DAC sample is due two cycles after the frame end
		checkEqual(waited, 2, "DAC latency in cycles");
	endtask

	// --------------------
	// Compare process
	// --------------------
	always @(negedge clk) begin
		expect_t e;
		if (dacValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("DAC output valid at %0t ns without a pending frame", $time);
				abortRun();
			end else begin
				e = expQ.pop_front();
				checkEqual(dac.left, e.dac.left, "o_dac.left");
				checkEqual(dac.right, e.dac.right, "o_dac.right");
				checkEqual(lineIn, e.lineIn, "o_lineIn");
				checkEqual(storedCd.left, e.storedCd.left, "o_storedCd.left");
				checkEqual(storedCd.right, e.storedCd.right, "o_storedCd.right");
				checkedCount++;
			end
		end
	end

	initial begin
		rst = 1'b1;
		voiceValid = 1'b0;
		voice = '0;
		frameEnd = 1'b0;
		cdValid = 1'b0;
		cdSample = '0;
		regs = '0;
		reverbReturn = '0;
		modelSide = SIDE_LEFT;
		modelCd = '0;
		modelRevLeft = '0;
		modelRevRight = '0;
		frameCount = 0;
		checkedCount = 0;
		errorCount = 0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		// Quiet outputs after reset
		checkEqual(dacValid, 0, "o_dacValid after reset");
		checkEqual(cdDropped, 0, "o_cdDropped after reset");
		checkEqual(dac, 0, "o_dac after reset");
		checkEqual(lineIn, 0, "o_lineIn after reset");
		checkEqual(storedCd, 0, "o_storedCd after reset");
		for (i = 0; i < 3; i++) runFrame(0, 0);
		// Random frames, push counts from none to overflow
		for (i = 0; i < 48; i++) begin
			randomRegs();
			case (randBelow(8))
				0, 1:       runFrame(randBelow(MAX_VOICES + 1), 0);
				2, 3, 4, 5: runFrame(randBelow(MAX_VOICES + 1), 1 + randBelow(2));
				6:          runFrame(randBelow(MAX_VOICES + 1), randBelow(4));
				default:    runFrame(randBelow(MAX_VOICES + 1), CD_DEPTH + 1 + randBelow(3));
			endcase
		end
		// Forced overflow, then drain past empty
		randomRegs();
		regs.cdEnable = 1'b1;
		runFrame(4, CD_DEPTH + 3);
		for (i = 0; i < CD_DEPTH + 3; i++) runFrame(randBelow(8), 0);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
source/spuMixPkg.sv
source/voiceSummer.sv
source/cdAudioFifo.sv
source/audioMixer.sv
source/spuAudioOut.sv
bench/spuAudioOutTb.sv
